/* addr_gen/addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_gen (
   input  wire                      clk,
   input  wire                      rst,
   input  wire stream_pkg::ag_cfg_t cfg_i,
   input  wire                      start_i,
   output logic                     rd_en_o,
   output stream_pkg::mem_addr_t    rd_addr_o,
   output logic                     rd_last_o
);

   typedef enum logic [1:0] {st_idle, st_wait, st_run} state_t;

   state_t                           state;
   stream_pkg::ag_cfg_t              cfg_q;
   stream_pkg::ag_cfg_t              cur_cfg;
   logic [stream_pkg::DELAY_W-1:0]   dly_cnt;
   logic [stream_pkg::CNT_W-1:0]     step_cnt;
   logic [stream_pkg::CNT_W-1:0]     iter_cnt;
   logic [stream_pkg::CNT_W-1:0]     step_nxt;
   logic [stream_pkg::CNT_W-1:0]     iter_nxt;
   stream_pkg::mem_addr_t            base;
   logic                             launch;
   logic                             wrap;

   // zero count behaves like one
   function automatic logic [stream_pkg::CNT_W-1:0] lim_m1(
      input logic [stream_pkg::CNT_W-1:0] n
   );
      return (n == '0) ? '0 : n - 1'b1;
   endfunction

   assign cur_cfg = (state == st_idle) ? cfg_i : cfg_q;
   assign launch  = (state == st_idle && start_i && cfg_i.delay == '0) ||
                    (state == st_wait && dly_cnt == 1);
   assign wrap     = (step_cnt == lim_m1(cfg_q.per));
   assign step_nxt = wrap ? '0 : step_cnt + 1'b1;
   assign iter_nxt = wrap ? iter_cnt + 1'b1 : iter_cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= st_idle;
         cfg_q     <= '0;
         dly_cnt   <= '0;
         step_cnt  <= '0;
         iter_cnt  <= '0;
         base      <= '0;
         rd_en_o   <= 1'b0;
         rd_addr_o <= '0;
         rd_last_o <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (start_i) begin
                  cfg_q   <= cfg_i;
                  dly_cnt <= cfg_i.delay;
                  state   <= st_wait;
               end
            end
            st_wait: dly_cnt <= dly_cnt - 1'b1;
            default: begin
               if (rd_last_o) begin
                  rd_en_o   <= 1'b0;
                  rd_last_o <= 1'b0;
                  state     <= st_idle;
               end else begin
                  step_cnt  <= step_nxt;
                  iter_cnt  <= iter_nxt;
                  rd_last_o <= (step_nxt == lim_m1(cfg_q.per)) &&
                               (iter_nxt == lim_m1(cfg_q.iter));
                  // next iteration starts from the shifted base
                  if (wrap) begin
                     base      <= base + cfg_q.shift;
                     rd_addr_o <= base + cfg_q.shift;
                  end else begin
                     rd_addr_o <= rd_addr_o + cfg_q.incr;
                  end
               end
            end
         endcase
         // first address, overrides the state step above
         if (launch) begin
            rd_en_o   <= 1'b1;
            rd_addr_o <= cur_cfg.start;
            base      <= cur_cfg.start;
            step_cnt  <= '0;
            iter_cnt  <= '0;
            rd_last_o <= (lim_m1(cur_cfg.per) == '0) && (lim_m1(cur_cfg.iter) == '0);
            state     <= st_run;
         end
      end
   end

endmodule

`default_nettype wire

/* common/ram_wr_if.sv */
`timescale 1ns/1ps
`default_nettype none

// write side of the stream memory
interface ram_wr_if;

   stream_pkg::mem_addr_t       addr;
   stream_pkg::word_t           data;
   logic [stream_pkg::SEL_W-1:0] strb;
   logic                        we;

   modport writer (
      output addr,
      output data,
      output strb,
      output we
   );

   modport mem (
      input addr,
      input data,
      input strb,
      input we
   );

endinterface

`default_nettype wire

/* common/stream_pkg.sv */
`default_nettype none

package stream_pkg;

   localparam int DATA_W    = 32;
   localparam int SEL_W     = DATA_W / 8;
   localparam int MEM_AW    = 10;
   localparam int MEM_DEPTH = 1 << MEM_AW;
   // bit WB_AW-1 selects the memory region
   localparam int WB_AW     = 12;
   localparam int CNT_W     = 10;
   localparam int DELAY_W   = 7;
   // cycles from address to stream word
   localparam int STREAM_LAT = 2;

   localparam int REG_IDX_W = 3;
   localparam logic [REG_IDX_W-1:0] REG_CTRL   = 3'd0;
   localparam logic [REG_IDX_W-1:0] REG_STATUS = 3'd1;
   localparam logic [REG_IDX_W-1:0] REG_START  = 3'd2;
   localparam logic [REG_IDX_W-1:0] REG_INCR   = 3'd3;
   localparam logic [REG_IDX_W-1:0] REG_SHIFT  = 3'd4;
   localparam logic [REG_IDX_W-1:0] REG_PER    = 3'd5;
   localparam logic [REG_IDX_W-1:0] REG_ITER   = 3'd6;
   localparam logic [REG_IDX_W-1:0] REG_DELAY  = 3'd7;

   typedef logic [DATA_W-1:0] word_t;
   typedef logic [MEM_AW-1:0] mem_addr_t;

   // address pattern of one run
   typedef struct packed {
      mem_addr_t           start;
      mem_addr_t           incr;
      mem_addr_t           shift;
      logic [CNT_W-1:0]    per;
      logic [CNT_W-1:0]    iter;
      logic [DELAY_W-1:0]  delay;
   } ag_cfg_t;

endpackage

`default_nettype wire

/* hw/output_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module output_mem (
   input  wire                        clk,
   input  wire                        rst,
   ram_wr_if.mem                      wr,
   input  wire                        rd_en_i,
   input  wire stream_pkg::mem_addr_t rd_addr_i,
   input  wire                        rd_last_i,
   output logic                       strm_valid_o,
   output stream_pkg::word_t          strm_data_o,
   output logic                       strm_last_o
);

   stream_pkg::word_t                  ram [stream_pkg::MEM_DEPTH];
   stream_pkg::word_t                  rd_q;
   stream_pkg::word_t                  out_q;
   logic [stream_pkg::STREAM_LAT-1:0]  vld_pipe;
   logic [stream_pkg::STREAM_LAT-1:0]  last_pipe;

   // byte lane write, registered read, then output register
   always_ff @(posedge clk) begin
      for (int b = 0; b < stream_pkg::SEL_W; b++) begin
         if (wr.we && wr.strb[b]) begin
            ram[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
         end
      end
      if (rd_en_i) begin
         rd_q <= ram[rd_addr_i];
      end
      out_q <= rd_q;
   end

   // valid and last follow the data stages
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vld_pipe  <= '0;
         last_pipe <= '0;
      end else begin
         vld_pipe  <= {vld_pipe[stream_pkg::STREAM_LAT-2:0], rd_en_i};
         last_pipe <= {last_pipe[stream_pkg::STREAM_LAT-2:0], rd_en_i & rd_last_i};
      end
   end

   assign strm_valid_o = vld_pipe[stream_pkg::STREAM_LAT-1];
   assign strm_last_o  = last_pipe[stream_pkg::STREAM_LAT-1];
   // idle stream reads as zero
   assign strm_data_o  = strm_valid_o ? out_q : '0;

endmodule

`default_nettype wire

/* hw/stream_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_ctrl (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          wb_cyc_i,
   input  wire                          wb_stb_i,
   input  wire                          wb_we_i,
   input  wire [stream_pkg::WB_AW-1:0]  wb_adr_i,
   input  wire [stream_pkg::SEL_W-1:0]  wb_sel_i,
   input  wire stream_pkg::word_t       wb_dat_i,
   output stream_pkg::word_t            wb_dat_o,
   output logic                         wb_ack_o,
   ram_wr_if.writer                     mem,
   output stream_pkg::ag_cfg_t          cfg_o,
   output logic                         start_o,
   input  wire                          strm_last_i,
   output logic                         done_o
);

   typedef enum logic [1:0] {st_idle, st_busy, st_dis} state_t;

   state_t                              state;
   logic                                req;
   logic                                mem_sel;
   logic                                reg_wr;
   logic                                run_wr;
   logic                                busy;
   logic                                dis_q;
   logic [stream_pkg::REG_IDX_W-1:0]    reg_idx;
   stream_pkg::ag_cfg_t                 cfg_q;
   stream_pkg::word_t                   rd_word;

   // no request in the cycle that carries an ack
   assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign mem_sel = wb_adr_i[stream_pkg::WB_AW-1];
   assign reg_idx = wb_adr_i[stream_pkg::REG_IDX_W-1:0];
   assign reg_wr  = req & wb_we_i & ~mem_sel;
   assign run_wr  = reg_wr & (reg_idx == stream_pkg::REG_CTRL) & wb_dat_i[0];
   assign busy    = (state != st_idle);

   // memory write lands on the same edge as the ack
   assign mem.we   = req & wb_we_i & mem_sel;
   assign mem.addr = wb_adr_i[stream_pkg::MEM_AW-1:0];
   assign mem.data = wb_dat_i;
   assign mem.strb = wb_sel_i;

   assign cfg_o = cfg_q;

   // register readback, memory region reads as zero
   always_comb begin
      rd_word = '0;
      if (!mem_sel) begin
         case (reg_idx)
            stream_pkg::REG_CTRL:   rd_word = stream_pkg::word_t'({dis_q, 1'b0});
            stream_pkg::REG_STATUS: rd_word = stream_pkg::word_t'({done_o, busy});
            stream_pkg::REG_START:  rd_word = stream_pkg::word_t'(cfg_q.start);
            stream_pkg::REG_INCR:   rd_word = stream_pkg::word_t'(cfg_q.incr);
            stream_pkg::REG_SHIFT:  rd_word = stream_pkg::word_t'(cfg_q.shift);
            stream_pkg::REG_PER:    rd_word = stream_pkg::word_t'(cfg_q.per);
            stream_pkg::REG_ITER:   rd_word = stream_pkg::word_t'(cfg_q.iter);
            default:                rd_word = stream_pkg::word_t'(cfg_q.delay);
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wb_ack_o <= 1'b0;
         wb_dat_o <= '0;
         cfg_q    <= '0;
         dis_q    <= 1'b0;
      end else begin
         wb_ack_o <= req;
         if (req && !wb_we_i) begin
            wb_dat_o <= rd_word;
         end
         if (reg_wr) begin
            case (reg_idx)
               stream_pkg::REG_CTRL:  dis_q       <= wb_dat_i[1];
               stream_pkg::REG_START: cfg_q.start <= wb_dat_i[stream_pkg::MEM_AW-1:0];
               stream_pkg::REG_INCR:  cfg_q.incr  <= wb_dat_i[stream_pkg::MEM_AW-1:0];
               stream_pkg::REG_SHIFT: cfg_q.shift <= wb_dat_i[stream_pkg::MEM_AW-1:0];
               stream_pkg::REG_PER:   cfg_q.per   <= wb_dat_i[stream_pkg::CNT_W-1:0];
               stream_pkg::REG_ITER:  cfg_q.iter  <= wb_dat_i[stream_pkg::CNT_W-1:0];
               stream_pkg::REG_DELAY: cfg_q.delay <= wb_dat_i[stream_pkg::DELAY_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // run sequencing, run writes while busy are dropped
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= st_idle;
         start_o <= 1'b0;
         done_o  <= 1'b0;
      end else begin
         start_o <= 1'b0;
         case (state)
            st_idle: begin
               if (run_wr) begin
                  done_o <= 1'b0;
                  if (wb_dat_i[1]) begin
                     state <= st_dis;
                  end else begin
                     start_o <= 1'b1;
                     state   <= st_busy;
                  end
               end
            end
            st_busy: begin
               if (strm_last_i) begin
                  done_o <= 1'b1;
                  state  <= st_idle;
               end
            end
            default: begin
               // disabled run finishes without output
               done_o <= 1'b1;
               state  <= st_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/stream_source_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_source_top (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          wb_cyc_i,
   input  wire                          wb_stb_i,
   input  wire                          wb_we_i,
   input  wire [stream_pkg::WB_AW-1:0]  wb_adr_i,
   input  wire [stream_pkg::SEL_W-1:0]  wb_sel_i,
   input  wire stream_pkg::word_t       wb_dat_i,
   output stream_pkg::word_t            wb_dat_o,
   output logic                         wb_ack_o,
   output logic                         strm_valid_o,
   output stream_pkg::word_t            strm_data_o,
   output logic                         done_o
);

   stream_pkg::ag_cfg_t      ag_cfg;
   stream_pkg::mem_addr_t    rd_addr;
   logic                     ag_start;
   logic                     rd_en;
   logic                     rd_last;
   logic                     strm_last;

   ram_wr_if mem_wr ();

   stream_ctrl ctrl0 (
      .clk         (clk),
      .rst         (rst),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_sel_i    (wb_sel_i),
      .wb_dat_i    (wb_dat_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .mem         (mem_wr.writer),
      .cfg_o       (ag_cfg),
      .start_o     (ag_start),
      .strm_last_i (strm_last),
      .done_o      (done_o)
   );

   addr_gen agen0 (
      .clk       (clk),
      .rst       (rst),
      .cfg_i     (ag_cfg),
      .start_i   (ag_start),
      .rd_en_o   (rd_en),
      .rd_addr_o (rd_addr),
      .rd_last_o (rd_last)
   );

   output_mem omem0 (
      .clk          (clk),
      .rst          (rst),
      .wr           (mem_wr.mem),
      .rd_en_i      (rd_en),
      .rd_addr_i    (rd_addr),
      .rd_last_i    (rd_last),
      .strm_valid_o (strm_valid_o),
      .strm_data_o  (strm_data_o),
      .strm_last_o  (strm_last)
   );

endmodule

`default_nettype wire

/* tests/stream_source_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_source_sva (
   input wire                    clk,
   input wire                    rst,
   input wire                    wb_cyc_i,
   input wire                    wb_stb_i,
   input wire                    wb_ack_o,
   input wire                    strm_valid_o,
   input wire stream_pkg::word_t strm_data_o
);

   int err_cnt = 0;

   ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
      wb_ack_o |=> !wb_ack_o)
      else begin
         err_cnt++;
         $error("wb_ack_o stayed high for more than one cycle");
      end

   // ack answers a request seen on the previous edge
   ack_after_req: assert property (@(posedge clk) disable iff (rst)
      wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
      else begin
         err_cnt++;
         $error("wb_ack_o raised without a bus request");
      end

   valid_low_after_rst: assert property (@(posedge clk)
      $past(rst) |-> !strm_valid_o)
      else begin
         err_cnt++;
         $error("strm_valid_o high right after reset");
      end

   idle_data_zero: assert property (@(posedge clk) disable iff (rst)
      !strm_valid_o |-> (strm_data_o == '0))
      else begin
         err_cnt++;
         $error("strm_data_o not zero while strm_valid_o is low");
      end

endmodule

`default_nettype wire

/* tests/tb_stream_source.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stream_source;

   // run length of a test is per*iter + delay
   localparam int RUN_CYCLES     = (16 + 0) + (20 + 0) + (1 + 0) + (16 + 9) + (12 + 12) +
                                   (12 + 12);
   // bus accesses of all six tests
   localparam int BUS_OPS        = 14 + 1031 + 7 + 10 + 7 + 11;
   localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES + 50 * BUS_OPS;

   logic                          clk;
   logic                          rst;
   logic                          wb_cyc;
   logic                          wb_stb;
   logic                          wb_we;
   logic [stream_pkg::WB_AW-1:0]  wb_adr;
   logic [stream_pkg::SEL_W-1:0]  wb_sel;
   stream_pkg::word_t             wb_wdat;
   stream_pkg::word_t             wb_rdat;
   logic                          wb_ack;
   logic                          strm_valid;
   stream_pkg::word_t             strm_data;
   logic                          done;

   stream_pkg::word_t             model [stream_pkg::MEM_DEPTH];
   stream_pkg::word_t             exp_q [$];
   int                            cycle_cnt = 0;
   int                            cfg_start;
   int                            cfg_incr;
   int                            cfg_shift;
   int                            cfg_per;
   int                            cfg_iter;
   int                            cfg_delay;

   stream_source_top dut0 (
      .clk          (clk),
      .rst          (rst),
      .wb_cyc_i     (wb_cyc),
      .wb_stb_i     (wb_stb),
      .wb_we_i      (wb_we),
      .wb_adr_i     (wb_adr),
      .wb_sel_i     (wb_sel),
      .wb_dat_i     (wb_wdat),
      .wb_dat_o     (wb_rdat),
      .wb_ack_o     (wb_ack),
      .strm_valid_o (strm_valid),
      .strm_data_o  (strm_data),
      .done_o       (done)
   );

   bind stream_source_top stream_source_sva sva0 (
      .clk          (clk),
      .rst          (rst),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_ack_o     (wb_ack_o),
      .strm_valid_o (strm_valid_o),
      .strm_data_o  (strm_data_o)
   );

   always #2 clk = ~clk;

   task stop_with_error();
      $display("Finished with errors");
      $fatal(1, "run stopped at the first error");
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
         stop_with_error();
      end
   end

   task automatic compare_word(input string name, input stream_pkg::word_t got,
                               input stream_pkg::word_t exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h, expected %h", name, got, exp);
         stop_with_error();
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h, expected %h", name, got, exp);
         stop_with_error();
      end
   endtask

   function automatic logic [stream_pkg::WB_AW-1:0] reg_adr(
      input logic [stream_pkg::REG_IDX_W-1:0] idx
   );
      logic [stream_pkg::WB_AW-1:0] adr;
      adr = '0;
      adr[stream_pkg::REG_IDX_W-1:0] = idx;
      return adr;
   endfunction

   // top address bit picks the memory region
   function automatic logic [stream_pkg::WB_AW-1:0] mem_adr(input int a);
      logic [stream_pkg::WB_AW-1:0] adr;
      adr = '0;
      adr[stream_pkg::WB_AW-1] = 1'b1;
      adr[stream_pkg::MEM_AW-1:0] = stream_pkg::mem_addr_t'(a);
      return adr;
   endfunction

   task automatic wb_write(input logic [stream_pkg::WB_AW-1:0] adr,
                           input stream_pkg::word_t dat,
                           input logic [stream_pkg::SEL_W-1:0] sel);
      @(posedge clk);
      wb_cyc  <= 1'b1;
      wb_stb  <= 1'b1;
      wb_we   <= 1'b1;
      wb_adr  <= adr;
      wb_wdat <= dat;
      wb_sel  <= sel;
      do @(posedge clk); while (!wb_ack);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      // lane merge into the model
      if (adr[stream_pkg::WB_AW-1]) begin
         for (int b = 0; b < stream_pkg::SEL_W; b++) begin
            if (sel[b]) begin
               model[adr[stream_pkg::MEM_AW-1:0]][8*b +: 8] = dat[8*b +: 8];
            end
         end
      end
   endtask

   task automatic wb_read(input logic [stream_pkg::WB_AW-1:0] adr,
                          output stream_pkg::word_t dat);
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= 1'b0;
      wb_adr <= adr;
      wb_sel <= '1;
      do @(posedge clk); while (!wb_ack);
      dat = wb_rdat;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   task automatic read_check(input logic [stream_pkg::WB_AW-1:0] adr, input string name,
                             input stream_pkg::word_t exp);
      stream_pkg::word_t got;
      wb_read(adr, got);
      compare_word($sformatf("wb_dat_o %s", name), got, exp);
   endtask

   task automatic set_cfg(input int start, input int incr, input int shift, input int per,
                          input int iter, input int delay);
      cfg_start = start;
      cfg_incr  = incr;
      cfg_shift = shift;
      cfg_per   = per;
      cfg_iter  = iter;
      cfg_delay = delay;
      wb_write(reg_adr(stream_pkg::REG_START), stream_pkg::word_t'(start), '1);
      wb_write(reg_adr(stream_pkg::REG_INCR), stream_pkg::word_t'(incr), '1);
      wb_write(reg_adr(stream_pkg::REG_SHIFT), stream_pkg::word_t'(shift), '1);
      wb_write(reg_adr(stream_pkg::REG_PER), stream_pkg::word_t'(per), '1);
      wb_write(reg_adr(stream_pkg::REG_ITER), stream_pkg::word_t'(iter), '1);
      wb_write(reg_adr(stream_pkg::REG_DELAY), stream_pkg::word_t'(delay), '1);
   endtask

   // expected words follow start + i*shift + j*incr modulo the depth
   task automatic start_run(input logic dis);
      int p;
      int it;
      p  = (cfg_per == 0) ? 1 : cfg_per;
      it = (cfg_iter == 0) ? 1 : cfg_iter;
      exp_q.delete();
      for (int i = 0; i < it; i++) begin
         for (int j = 0; j < p; j++) begin
            exp_q.push_back(model[(cfg_start + i * cfg_shift + j * cfg_incr) %
                                  stream_pkg::MEM_DEPTH]);
         end
      end
      wb_write(reg_adr(stream_pkg::REG_CTRL), stream_pkg::word_t'({dis, 1'b1}), '1);
   endtask

   task automatic wait_done();
      while (!done) begin
         if (strm_valid) begin
            $display("strm_valid_o rose while no stream word was expected");
            stop_with_error();
         end
         @(posedge clk);
      end
   endtask

   task automatic idle_check(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         if (strm_valid) begin
            $display("strm_valid_o rose on an idle stream");
            stop_with_error();
         end
      end
   endtask

   // exp_lat counts edges from the return of the last bus write
   task automatic collect_stream(input int exp_lat);
      int lat;
      int n;
      lat = 0;
      n   = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!strm_valid);
      compare_word("first valid latency", stream_pkg::word_t'(lat),
                   stream_pkg::word_t'(exp_lat));
      while (strm_valid) begin
         if (n < exp_q.size()) begin
            compare_word("strm_data_o", strm_data, exp_q[n]);
         end
         compare_bit("done_o", done, 1'b0);
         n++;
         @(posedge clk);
      end
      compare_word("stream word count", stream_pkg::word_t'(n),
                   stream_pkg::word_t'(exp_q.size()));
      wait_done();
   endtask

   task automatic check_registers();
      read_check(reg_adr(stream_pkg::REG_STATUS), "status after reset", '0);
      set_cfg(32'h2a5, 32'h13, 32'h3ff, 32'h155, 32'h0aa, 32'h5c);
      read_check(reg_adr(stream_pkg::REG_START), "reg start", 32'h2a5);
      read_check(reg_adr(stream_pkg::REG_INCR), "reg incr", 32'h13);
      read_check(reg_adr(stream_pkg::REG_SHIFT), "reg shift", 32'h3ff);
      read_check(reg_adr(stream_pkg::REG_PER), "reg per", 32'h155);
      read_check(reg_adr(stream_pkg::REG_ITER), "reg iter", 32'h0aa);
      read_check(reg_adr(stream_pkg::REG_DELAY), "reg delay", 32'h5c);
      read_check(mem_adr(123), "memory region read", '0);
   endtask

   task automatic run_linear();
      for (int a = 0; a < stream_pkg::MEM_DEPTH; a++) begin
         wb_write(mem_adr(a), stream_pkg::word_t'($urandom), '1);
      end
      set_cfg(5, 1, 0, 16, 1, 0);
      start_run(1'b0);
      collect_stream(cfg_delay + 3);
   endtask

   task automatic run_wrapped();
      set_cfg(1000, 3, 40, 4, 5, 0);
      start_run(1'b0);
      collect_stream(cfg_delay + 3);
   endtask

   task automatic merge_lanes();
      wb_write(mem_adr(77), 32'h11223344, 4'b1111);
      wb_write(mem_adr(77), 32'haabbccdd, 4'b0101);
      wb_write(mem_adr(77), 32'h55667788, 4'b1000);
      set_cfg(77, 0, 0, 1, 1, 0);
      start_run(1'b0);
      collect_stream(cfg_delay + 3);
   endtask

   // valid rises delay + 3 edges after the ack edge of the run write
   task automatic measure_latency();
      set_cfg(300, 5, 100, 8, 2, 9);
      start_run(1'b0);
      collect_stream(12);
   endtask

   task automatic disable_and_done();
      set_cfg(200, 2, 0, 6, 2, 12);
      start_run(1'b1);
      // done clears on the run write and sets one cycle later
      compare_bit("done_o", done, 1'b0);
      @(posedge clk);
      compare_bit("done_o", done, 1'b1);
      idle_check(20);
      read_check(reg_adr(stream_pkg::REG_STATUS), "status after disabled run", 32'h2);
      start_run(1'b0);
      // second run write lands while busy
      wb_write(reg_adr(stream_pkg::REG_CTRL), 32'h1, '1);
      compare_bit("done_o", done, 1'b0);
      // the busy write uses three of the delay + 3 edges
      collect_stream(cfg_delay);
      idle_check(20);
      read_check(reg_adr(stream_pkg::REG_STATUS), "status after run", 32'h2);
   endtask

   initial begin
      void'($urandom(84718));
      clk     = 1'b0;
      rst     = 1'b1;
      wb_cyc  = 1'b0;
      wb_stb  = 1'b0;
      wb_we   = 1'b0;
      wb_adr  = '0;
      wb_sel  = '0;
      wb_wdat = '0;
      for (int a = 0; a < stream_pkg::MEM_DEPTH; a++) begin
         model[a] = '0;
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_registers();
      run_linear();
      run_wrapped();
      merge_lanes();
      measure_latency();
      disable_and_done();
      idle_check(4);
      if (dut0.sva0.err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
common/stream_pkg.sv
common/ram_wr_if.sv
hw/stream_ctrl.sv
addr_gen/addr_gen.sv
hw/output_mem.sv
hw/stream_source_top.sv
tests/stream_source_sva.sv
tests/tb_stream_source.sv
